// ==== conv_top.f ====
src/conv_pkg.sv
src/conv_ctrl.sv
src/row_window.sv
src/majority_vote.sv
src/row_packer.sv
src/conv_top.sv
verif/tb_clock.sv
verif/conv_props.sv
verif/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert --top-module conv_tb -f conv_top.f -o conv_sim \
	&& ./obj_dir/conv_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
	&& echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== verif/conv_tb.sv ====
// golden rows held for at most 16 output rows per run with random data seeded with 71
`timescale 1ns/1ps
module conv_tb;
	import conv_pkg::*;

	logic clk;
	logic reset_b;
	logic dut_run = 1'b0;
	logic dut_busy;
	logic [addr_w-1:0] dut_sram_read_address;
	logic [word_w-1:0] sram_dut_read_data = '0;
	logic [addr_w-1:0] dut_wmem_read_address;
	logic [word_w-1:0] wmem_dut_read_data = '0;
	logic [addr_w-1:0] dut_sram_write_address;
	logic [word_w-1:0] dut_sram_write_data;
	logic dut_sram_write_enable;
	// memory models and golden rows
	logic [word_w-1:0] in_mem [0:(1<<addr_w)-1];
	logic [word_w-1:0] wmem [0:(1<<addr_w)-1];
	logic [word_w-1:0] expect_word [0:15];
	int write_cnt = 0;
	int write_errors = 0;
	int run_errors = 0;
	int timeouts = 0;
	logic [8:0] kern;

	tb_clock u_tb_clock (.clk(clk), .reset_b(reset_b));

	conv_top u_conv_top (.*);

	// one cycle read latency on both memories
	always @(posedge clk) begin
		sram_dut_read_data <= in_mem[dut_sram_read_address];
		wmem_dut_read_data <= wmem[dut_wmem_read_address];
	end

	// row r bit c set when at least 5 of 9 input bits equal their weight
	function automatic logic [word_w-1:0] golden_row(input int r, input int w, input logic [8:0] k);
		logic [word_w-1:0] res;
		int same;
		res = '0;
		for (int c = 0; c <= w - 3; c++) begin
			same = 0;
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					if (in_mem[addr_w'(first_row_addr + r + i)][col_w'(c + j)] == k[4'(3 * i + j)])
						same++;
				end
			end
			res[col_w'(c)] = (same >= vote_min);
		end
		return res;
	endfunction

	// rows must come out in order and the counter restarts with each run
	always @(posedge clk) begin
		if (dut_run && !dut_busy) begin
			write_cnt <= 0;
		end else if (reset_b && dut_sram_write_enable) begin
			assert (dut_sram_write_address == addr_w'(write_cnt)) else begin
				write_errors++;
				$display("ERROR at %0t: write address %0d, expected %0d", $time,
					dut_sram_write_address, write_cnt);
			end
			assert (dut_sram_write_data == expect_word[4'(write_cnt)]) else begin
				write_errors++;
				$display("ERROR at %0t: row %0d wrote %h, expected %h", $time, write_cnt,
					dut_sram_write_data, expect_word[4'(write_cnt)]);
			end
			write_cnt <= write_cnt + 1;
		end
	end

	// header words followed by random rows or all ones
	task automatic load_image(input int h, input int w, input bit random_rows);
		in_mem[dims_rows_addr] = word_w'(h);
		in_mem[dims_cols_addr] = word_w'(w);
		for (int r = 0; r < h; r++) begin
			in_mem[addr_w'(first_row_addr + r)] = random_rows ? word_w'($urandom) : '1;
		end
	endtask

	task automatic wait_busy(input logic level, input int limit);
		int n;
		n = 0;
		while (dut_busy !== level && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (dut_busy !== level) begin
			timeouts++;
			$display("timeout: dut_busy never went to %0b within %0d cycles", level, limit);
		end
	endtask

	// pulse run and check the row count once busy drops
	task automatic run_image(input int h, input int w, input logic [8:0] k);
		wmem[weight_addr] = word_w'(k);
		for (int r = 0; r < h - 2; r++) begin
			expect_word[4'(r)] = golden_row(r, w, k);
		end
		@(posedge clk);
		dut_run <= 1'b1;
		@(posedge clk);
		dut_run <= 1'b0;
		wait_busy(1'b1, 10);
		wait_busy(1'b0, 2000);
		assert (write_cnt == h - 2) else begin
			run_errors++;
			$display("ERROR at %0t: %0d rows written, expected %0d", $time, write_cnt, h - 2);
		end
	endtask

	initial begin
		void'($urandom(71));
		wmem[0] = '0;
		// idle past reset while busy stays low
		repeat (10) @(posedge clk);
		kern = 9'($urandom);
		load_image(8, 16, 1'b1);
		run_image(8, 16, kern);
		// back to back with the inverted kernel
		run_image(8, 16, ~kern);
		// columns 3 and up must stay 0
		load_image(4, 5, 1'b0);
		run_image(4, 5, 9'h1ff);
		$display("errors: %0d write, %0d run, %0d timeout", write_errors, run_errors, timeouts);
		if (write_errors + run_errors + timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end
endmodule

// ==== verif/conv_props.sv ====
// bound into conv_top, checks hold only while reset_b is high
`timescale 1ns/1ps
module conv_props (
	input logic clk,
	input logic reset_b,
	input logic dut_run,
	input logic dut_busy,
	input logic dut_sram_write_enable
);
	// busy only rises on a run request
	assert property (@(posedge clk) disable iff (!reset_b) !dut_busy && !dut_run |=> !dut_busy)
		else $error("dut_busy rose without a dut_run pulse");
	// no write outside a run
	assert property (@(posedge clk) disable iff (!reset_b) !dut_busy |-> !dut_sram_write_enable)
		else $error("write enable high while dut_busy is low");
	// write enable is a single-cycle strobe
	assert property (@(posedge clk) disable iff (!reset_b)
		dut_sram_write_enable |=> !dut_sram_write_enable)
		else $error("write enable high for two cycles in a row");
endmodule

bind conv_top conv_props u_conv_props (
	.clk                   (clk),
	.reset_b               (reset_b),
	.dut_run               (dut_run),
	.dut_busy              (dut_busy),
	.dut_sram_write_enable (dut_sram_write_enable)
);

// ==== verif/tb_clock.sv ====
// free-running 10 ns clock, reset_b released on the fifth rising edge
`timescale 1ns/1ps
module tb_clock (
	output logic clk,
	output logic reset_b
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held low for 5 cycles
	initial begin
		reset_b = 1'b0;
		repeat (5) @(posedge clk);
		reset_b <= 1'b1;
	end
endmodule

// ==== src/conv_top.sv ====
// one image per dut_run pulse, memories must return read data one cycle after the address
`timescale 1ns/1ps
module conv_top (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic                        dut_run,
	output logic                        dut_busy,
	output logic [conv_pkg::addr_w-1:0] dut_sram_read_address,
	input  logic [conv_pkg::word_w-1:0] sram_dut_read_data,
	output logic [conv_pkg::addr_w-1:0] dut_wmem_read_address,
	input  logic [conv_pkg::word_w-1:0] wmem_dut_read_data,
	output logic [conv_pkg::addr_w-1:0] dut_sram_write_address,
	output logic [conv_pkg::word_w-1:0] dut_sram_write_data,
	output logic                        dut_sram_write_enable
);
	import conv_pkg::*;

	// controller strobes
	logic weight_load;
	logic row_load;
	logic [1:0] row_slot;
	logic start;
	// datapath stages
	col_strobe_t col_strobe;
	window_t window;
	result_t result;

	conv_ctrl u_conv_ctrl (
		.clk                   (clk),
		.reset_b               (reset_b),
		.dut_run               (dut_run),
		.sram_dut_read_data    (sram_dut_read_data),
		.dut_busy              (dut_busy),
		.dut_sram_read_address (dut_sram_read_address),
		.dut_wmem_read_address (dut_wmem_read_address),
		.weight_load           (weight_load),
		.row_load              (row_load),
		.row_slot              (row_slot),
		.col_strobe            (col_strobe),
		.start                 (start)
	);

	row_window u_row_window (
		.clk                (clk),
		.reset_b            (reset_b),
		.sram_dut_read_data (sram_dut_read_data),
		.row_load           (row_load),
		.row_slot           (row_slot),
		.col_strobe         (col_strobe),
		.window             (window)
	);

	majority_vote u_majority_vote (
		.clk                (clk),
		.reset_b            (reset_b),
		.wmem_dut_read_data (wmem_dut_read_data),
		.weight_load        (weight_load),
		.window             (window),
		.result             (result)
	);

	row_packer u_row_packer (
		.clk                    (clk),
		.reset_b                (reset_b),
		.start                  (start),
		.result                 (result),
		.dut_sram_write_enable  (dut_sram_write_enable),
		.dut_sram_write_address (dut_sram_write_address),
		.dut_sram_write_data    (dut_sram_write_data)
	);

endmodule

// ==== src/row_packer.sv ====
// expects start before the first result of a run, columns never strobed stay 0
`timescale 1ns/1ps
module row_packer (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic                        start,
	input  conv_pkg::result_t           result,
	output logic                        dut_sram_write_enable,
	output logic [conv_pkg::addr_w-1:0] dut_sram_write_address,
	output logic [conv_pkg::word_w-1:0] dut_sram_write_data
);
	import conv_pkg::*;

	// word under construction
	logic [word_w-1:0] acc_word;
	logic [word_w-1:0] next_word;
	// output row, doubles as write address
	logic [addr_w-1:0] out_row;

	// merge incoming vote at its column
	assign next_word = acc_word | (word_w'(result.vote) << result.col);

	always_ff @(posedge clk) begin
		if (start) begin
			acc_word <= '0;
		end else if (result.valid) begin
			// last column flushes the word
			acc_word <= result.last ? '0 : next_word;
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			out_row <= '0;
			dut_sram_write_enable <= 1'b0;
			dut_sram_write_address <= '0;
			dut_sram_write_data <= '0;
		end else begin
			dut_sram_write_enable <= 1'b0;
			if (start) begin
				out_row <= '0;
			end else if (result.valid && result.last) begin
				// single-cycle write of the finished row
				dut_sram_write_enable <= 1'b1;
				dut_sram_write_address <= out_row;
				dut_sram_write_data <= next_word;
				out_row <= out_row + 1'b1;
			end
		end
	end

endmodule

// ==== src/majority_vote.sv ====
// kernel must be loaded by weight_load before the first window of a run
`timescale 1ns/1ps
module majority_vote (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic [conv_pkg::word_w-1:0] wmem_dut_read_data,
	input  logic                        weight_load,
	input  conv_pkg::window_t           window,
	output conv_pkg::result_t           result
);
	import conv_pkg::*;

	weight_word_u kernel_q;
	// per-row equality with the kernel
	logic [k_dim-1:0] match0;
	logic [k_dim-1:0] match1;
	logic [k_dim-1:0] match2;
	// stage 1 registers
	logic s1_valid;
	logic s1_last;
	logic [col_w-1:0] s1_col;
	logic [k_dim-1:0][1:0] s1_cnt;
	// up to nine matches
	logic [3:0] match_sum;

	// ones in a 3-bit row
	function automatic logic [1:0] count3(input logic [k_dim-1:0] m);
		return {1'b0, m[0]} + {1'b0, m[1]} + {1'b0, m[2]};
	endfunction

	always_ff @(posedge clk) begin
		if (weight_load) begin
			kernel_q.raw <= wmem_dut_read_data;
		end
	end

	// xnor of taps against kernel
	assign match0 = ~(window.tap_row0 ^ kernel_q.kern.k_row0);
	assign match1 = ~(window.tap_row1 ^ kernel_q.kern.k_row1);
	assign match2 = ~(window.tap_row2 ^ kernel_q.kern.k_row2);

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			s1_col <= '0;
			s1_cnt <= '0;
		end else begin
			s1_valid <= window.valid;
			if (window.valid) begin
				s1_last <= window.last;
				s1_col <= window.col;
				s1_cnt[0] <= count3(match0);
				s1_cnt[1] <= count3(match1);
				s1_cnt[2] <= count3(match2);
			end
		end
	end

	assign match_sum = 4'(s1_cnt[0]) + 4'(s1_cnt[1]) + 4'(s1_cnt[2]);

	// stage 2, threshold and tag
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			result <= '0;
		end else begin
			result.valid <= s1_valid;
			if (s1_valid) begin
				result.last <= s1_last;
				result.col <= s1_col;
				result.vote <= (match_sum >= 4'(vote_min));
			end
		end
	end

endmodule

// ==== src/row_window.sv ====
// strobed columns must stay within 0 to 13 so that col+2 lands inside the 16-bit row
`timescale 1ns/1ps
module row_window (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic [conv_pkg::word_w-1:0] sram_dut_read_data,
	input  logic                        row_load,
	input  logic [1:0]                  row_slot,
	input  conv_pkg::col_strobe_t       col_strobe,
	output conv_pkg::window_t           window
);
	import conv_pkg::*;

	// three image rows, top row is kernel row offset 0
	logic [word_w-1:0] row_top;
	logic [word_w-1:0] row_mid;
	logic [word_w-1:0] row_bot;

	always_ff @(posedge clk) begin
		if (row_load) begin
			case (row_slot)
				2'd0: begin
					row_top <= sram_dut_read_data;
				end
				2'd1: begin
					row_mid <= sram_dut_read_data;
				end
				2'd2: begin
					row_bot <= sram_dut_read_data;
				end
				default: begin
					// slide down one image row
					row_top <= row_mid;
					row_mid <= row_bot;
					row_bot <= sram_dut_read_data;
				end
			endcase
		end
	end

	// one window per strobe, one cycle later
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			window <= '0;
		end else begin
			window.valid <= col_strobe.valid;
			if (col_strobe.valid) begin
				window.last <= col_strobe.last;
				window.col <= col_strobe.col;
				// tap bit j is image column col+j
				window.tap_row0 <= row_top[col_strobe.col +: k_dim];
				window.tap_row1 <= row_mid[col_strobe.col +: k_dim];
				window.tap_row2 <= row_bot[col_strobe.col +: k_dim];
			end
		end
	end

endmodule

// ==== src/conv_ctrl.sv ====
// one image per run, width 3 to 16 and height 3 to 4093, memories read with one cycle latency
`timescale 1ns/1ps
module conv_ctrl (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic                        dut_run,
	input  logic [conv_pkg::word_w-1:0] sram_dut_read_data,
	output logic                        dut_busy,
	output logic [conv_pkg::addr_w-1:0] dut_sram_read_address,
	output logic [conv_pkg::addr_w-1:0] dut_wmem_read_address,
	output logic                        weight_load,
	output logic                        row_load,
	output logic [1:0]                  row_slot,
	output conv_pkg::col_strobe_t       col_strobe,
	output logic                        start
);
	import conv_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_header,
		st_fill,
		st_sweep,
		st_advance,
		st_drain
	} state_t;

	state_t state;
	// header step, or issue and wait phase in fill and advance
	logic [1:0] step;
	logic [2:0] drain_cnt;
	// image bounds, each held as size minus 2
	logic [addr_w-1:0] rows_m2;
	logic [col_w-1:0] cols_m2;
	logic [addr_w-1:0] row_cnt;
	logic [col_w-1:0] col_cnt;
	// row read in flight, becomes row_load one cycle later
	logic rd_req;
	logic [1:0] rd_slot;
	logic [word_w-1:0] dim_m2;
	logic col_last;
	logic row_last;

	// height and width arrive as raw words
	assign dim_m2 = sram_dut_read_data - word_w'(2);

	assign col_last = (col_cnt == cols_m2 - 1'b1);
	assign row_last = (row_cnt == rows_m2 - 1'b1);

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= st_idle;
			step <= '0;
			drain_cnt <= '0;
			rows_m2 <= '0;
			cols_m2 <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
			rd_req <= 1'b0;
			rd_slot <= '0;
			dut_busy <= 1'b0;
			dut_sram_read_address <= '0;
			dut_wmem_read_address <= '0;
			weight_load <= 1'b0;
			row_load <= 1'b0;
			row_slot <= '0;
			col_strobe <= '0;
			start <= 1'b0;
		end else begin
			// strobes default low
			start <= 1'b0;
			weight_load <= 1'b0;
			rd_req <= 1'b0;
			col_strobe <= '0;
			// read data shows up one cycle after the address
			row_load <= rd_req;
			row_slot <= rd_slot;
			case (state)
				st_idle: begin
					if (dut_run) begin
						dut_busy <= 1'b1;
						start <= 1'b1;
						step <= '0;
						dut_sram_read_address <= addr_w'(dims_rows_addr);
						state <= st_header;
					end
				end
				st_header: begin
					step <= step + 1'b1;
					case (step)
						2'd0: begin
							dut_sram_read_address <= addr_w'(dims_cols_addr);
						end
						2'd1: begin
							// height on the bus now
							rows_m2 <= dim_m2[addr_w-1:0];
							dut_wmem_read_address <= addr_w'(weight_addr);
							dut_sram_read_address <= addr_w'(first_row_addr);
							rd_req <= 1'b1;
							rd_slot <= 2'd0;
						end
						default: begin
							// width on the bus, kernel lands next cycle
							cols_m2 <= dim_m2[col_w-1:0];
							weight_load <= 1'b1;
							dut_sram_read_address <= dut_sram_read_address + 1'b1;
							rd_req <= 1'b1;
							rd_slot <= 2'd1;
							row_cnt <= '0;
							col_cnt <= '0;
							step <= '0;
							state <= st_fill;
						end
					endcase
				end
				st_fill, st_advance: begin
					step <= step + 1'b1;
					if (step == 2'd0) begin
						dut_sram_read_address <= dut_sram_read_address + 1'b1;
						rd_req <= 1'b1;
						// third fill row, or shift in the next row
						rd_slot <= (state == st_fill) ? 2'd2 : 2'd3;
					end else begin
						// row register settles before the first strobe samples it
						state <= st_sweep;
					end
				end
				st_sweep: begin
					col_strobe.valid <= 1'b1;
					col_strobe.last <= col_last;
					col_strobe.col <= col_cnt;
					col_cnt <= col_cnt + 1'b1;
					if (col_last) begin
						col_cnt <= '0;
						step <= '0;
						if (row_last) begin
							drain_cnt <= 3'(pipe_depth + 1);
							state <= st_drain;
						end else begin
							row_cnt <= row_cnt + 1'b1;
							state <= st_advance;
						end
					end
				end
				st_drain: begin
					// hold busy until the last write has gone out
					drain_cnt <= drain_cnt - 1'b1;
					if (drain_cnt == '0) begin
						dut_busy <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== src/conv_pkg.sv ====
// sizes are tied to the 16-bit memory word and the 3x3 kernel and do not scale
package conv_pkg;

	// memory word and address widths
	localparam int word_w = 16;
	localparam int addr_w = 12;
	// column index covers columns 0 to 15
	localparam int col_w = 4;

	// kernel side and majority threshold out of nine
	localparam int k_dim = 3;
	localparam int vote_min = 5;

	// input memory layout
	localparam int dims_rows_addr = 0;
	localparam int dims_cols_addr = 1;
	localparam int first_row_addr = 2;
	// kernel word in weight memory
	localparam int weight_addr = 1;

	// strobe to result bit, window stage plus two vote stages
	localparam int pipe_depth = 3;

	// k_row0 sits in the low bits, bit j is column offset j
	typedef struct packed {
		logic [word_w-3*k_dim-1:0] pad;
		logic [k_dim-1:0] k_row2;
		logic [k_dim-1:0] k_row1;
		logic [k_dim-1:0] k_row0;
	} kernel_t;

	// weight word as read from memory or as kernel rows
	typedef union packed {
		logic [word_w-1:0] raw;
		kernel_t kern;
	} weight_word_u;

	// one column position of the sweep
	typedef struct packed {
		logic valid;
		logic last;
		logic [col_w-1:0] col;
	} col_strobe_t;

	// 3x3 taps for one column, tap bit j is column col+j
	typedef struct packed {
		logic valid;
		logic last;
		logic [col_w-1:0] col;
		logic [k_dim-1:0] tap_row0;
		logic [k_dim-1:0] tap_row1;
		logic [k_dim-1:0] tap_row2;
	} window_t;

	// majority outcome for one column
	typedef struct packed {
		logic valid;
		logic last;
		logic [col_w-1:0] col;
		logic vote;
	} result_t;

endpackage
